// File: Bender.yml
package:
  name: mips_core

sources:
  - logic/isa_pkg.sv
  - logic/ctrl_pkg.sv
  - logic/alu.sv
  - logic/register_file.sv
  - logic/step_counter.sv
  - logic/mult_unit.sv
  - logic/control_fsm.sv
  - logic/mips_core.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_mips_core.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  ctrl_pkg::alu_op_t op,
	input  isa_pkg::word_t    a,
	input  isa_pkg::word_t    b,
	output isa_pkg::word_t    result,
	output logic              zero
);
	import isa_pkg::*;

	word_t diff;

	assign diff = a - b;

	always_comb begin
		case (op)
			ctrl_pkg::alu_add: result = a + b;
			ctrl_pkg::alu_sub: result = diff;
			ctrl_pkg::alu_and: result = a & b;
			default: result = {{(word_w - 1){1'b0}}, $signed(a) < $signed(b)}; // slt
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: logic/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
	input  logic             clock,
	input  logic             reset,
	input  isa_pkg::opcode_t opcode,
	input  isa_pkg::funct_t  funct,
	input  logic             zero,
	input  logic             ack,
	input  logic             mult_done,
	output ctrl_pkg::ctrl_t  ctrl
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	state_t state;
	state_t next_state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		ctrl = '0;
		next_state = state;
		case (state)
			st_reset: next_state = st_fetch;
			st_fetch: begin
				ctrl.mem_req = 1'b1; // address from pc
				if (ack) begin
					ctrl.ir_write = 1'b1;
					next_state = st_fetch_release;
				end
			end
			st_fetch_release: begin
				ctrl.alu_a_sel = a_pc;
				ctrl.alu_b_sel = b_four;
				ctrl.alu_op = alu_add;
				ctrl.pc_sel = pc_alu;
				if (!ack) begin
					ctrl.pc_write = 1'b1;
					next_state = st_decode;
				end
			end
			st_decode: begin
				ctrl.ab_write = 1'b1;
				ctrl.alu_a_sel = a_pc;
				ctrl.alu_b_sel = b_imm_sh;
				ctrl.alu_op = alu_add;
				ctrl.alu_out_write = 1'b1; // branch target, used only by beq/bne
				case (opcode)
					op_rtype: begin
						case (funct)
							fn_add, fn_sub, fn_and: next_state = st_exec_rtype;
							fn_slt: next_state = st_exec_slt;
							fn_mult: next_state = st_mult_start;
							fn_mfhi: next_state = st_move_hi;
							fn_mflo: next_state = st_move_lo;
							default: next_state = st_fetch;
						endcase
					end
					op_addi: next_state = st_exec_imm;
					op_slti: next_state = st_exec_slt;
					op_lw, op_sw: next_state = st_mem_addr;
					op_beq, op_bne: next_state = st_branch;
					op_j: next_state = st_jump;
					default: next_state = st_fetch; // no-op
				endcase
			end
			st_exec_rtype: begin
				ctrl.alu_a_sel = a_reg;
				ctrl.alu_b_sel = b_reg;
				ctrl.alu_out_write = 1'b1;
				case (funct)
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					default: ctrl.alu_op = alu_add;
				endcase
				next_state = st_alu_writeback;
			end
			st_exec_imm: begin
				ctrl.alu_a_sel = a_reg;
				ctrl.alu_b_sel = b_imm;
				ctrl.alu_op = alu_add;
				ctrl.alu_out_write = 1'b1;
				next_state = st_alu_writeback;
			end
			st_exec_slt: begin
				ctrl.alu_a_sel = a_reg;
				if (opcode == op_rtype) begin
					ctrl.alu_b_sel = b_reg;
				end else begin
					ctrl.alu_b_sel = b_imm; // slti
				end
				ctrl.alu_op = alu_slt;
				ctrl.alu_out_write = 1'b1;
				next_state = st_alu_writeback;
			end
			st_mem_addr: begin
				ctrl.alu_a_sel = a_reg;
				ctrl.alu_b_sel = b_imm;
				ctrl.alu_op = alu_add;
				ctrl.alu_out_write = 1'b1;
				if (opcode == op_lw) begin
					next_state = st_mem_read;
				end else begin
					next_state = st_mem_write;
				end
			end
			st_mem_read: begin
				ctrl.mem_req = 1'b1;
				ctrl.addr_from_alu = 1'b1;
				if (ack) begin
					ctrl.mdr_write = 1'b1;
					next_state = st_mem_release;
				end
			end
			st_mem_write: begin
				ctrl.mem_req = 1'b1;
				ctrl.mem_we = 1'b1;
				ctrl.addr_from_alu = 1'b1;
				if (ack) begin
					next_state = st_mem_release;
				end
			end
			st_mem_release: begin
				// access ends when ack falls
				if (!ack) begin
					if (opcode == op_lw) begin
						next_state = st_load_writeback;
					end else begin
						next_state = st_fetch;
					end
				end
			end
			st_load_writeback: begin
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel = dst_rt;
				ctrl.wb_sel = wb_mdr;
				next_state = st_fetch;
			end
			st_alu_writeback: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = wb_alu;
				if (opcode == op_rtype) begin
					ctrl.dst_sel = dst_rd;
				end else begin
					ctrl.dst_sel = dst_rt;
				end
				next_state = st_fetch;
			end
			st_branch: begin
				ctrl.alu_a_sel = a_reg;
				ctrl.alu_b_sel = b_reg;
				ctrl.alu_op = alu_sub; // zero when rs == rt
				ctrl.pc_sel = pc_alu_out;
				if (opcode == op_beq) begin
					ctrl.pc_write = zero;
				end else begin
					ctrl.pc_write = !zero; // bne
				end
				next_state = st_fetch;
			end
			st_jump: begin
				ctrl.pc_sel = pc_jump;
				ctrl.pc_write = 1'b1;
				next_state = st_fetch;
			end
			st_mult_start: begin
				ctrl.mult_start = 1'b1; // operands from a and b
				next_state = st_mult_wait;
			end
			st_mult_wait: begin
				ctrl.mult_step = 1'b1;
				if (mult_done) begin
					next_state = st_fetch;
				end
			end
			st_move_hi: begin
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel = dst_rd;
				ctrl.wb_sel = wb_hi;
				next_state = st_fetch;
			end
			st_move_lo: begin
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel = dst_rd;
				ctrl.wb_sel = wb_lo;
				next_state = st_fetch;
			end
			default: next_state = st_reset;
		endcase
	end

endmodule

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

	typedef enum logic [4:0] {
		st_reset,
		st_fetch,
		st_fetch_release, // wait for ack low, pc + 4
		st_decode,
		st_exec_rtype,
		st_exec_imm,
		st_exec_slt,
		st_mem_addr,
		st_mem_read,
		st_mem_write,
		st_mem_release,
		st_load_writeback,
		st_alu_writeback,
		st_branch,
		st_jump,
		st_mult_start,
		st_mult_wait,
		st_move_hi,
		st_move_lo
	} state_t;

	typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_slt} alu_op_t;
	typedef enum logic {a_pc, a_reg} alu_a_sel_t;
	typedef enum logic [1:0] {b_reg, b_four, b_imm, b_imm_sh} alu_b_sel_t;
	typedef enum logic [1:0] {wb_alu, wb_mdr, wb_hi, wb_lo} wb_sel_t;
	typedef enum logic {dst_rt, dst_rd} dst_sel_t;
	typedef enum logic [1:0] {pc_alu, pc_alu_out, pc_jump} pc_sel_t;

	typedef struct packed {
		logic pc_write;
		pc_sel_t pc_sel;
		logic ir_write;
		logic ab_write;
		alu_a_sel_t alu_a_sel;
		alu_b_sel_t alu_b_sel;
		alu_op_t alu_op;
		logic alu_out_write;
		logic mdr_write;
		logic reg_write;
		dst_sel_t dst_sel;
		wb_sel_t wb_sel;
		logic mem_req; // drives req directly
		logic mem_we;
		logic addr_from_alu; // else pc
		logic mult_start;
		logic mult_step;
	} ctrl_t;

	typedef struct packed {
		isa_pkg::word_t addr;
		isa_pkg::word_t wdata;
		logic we;
	} mem_req_t;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs = 32;
	localparam int imm_w = 16;
	localparam int target_w = 26;
	localparam int mult_steps = 32;
	localparam int mult_cnt_w = $clog2(mult_steps);

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	typedef struct packed {
		opcode_t opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt; // unused, no shifts
		funct_t funct;
	} r_fields_t;

	typedef struct packed {
		opcode_t opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [imm_w-1:0] imm;
	} i_fields_t;

	typedef struct packed {
		opcode_t opcode;
		logic [target_w-1:0] target;
	} j_fields_t;

	// one instruction word seen through the three formats
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_t;

	localparam opcode_t op_rtype = 6'h00;
	localparam opcode_t op_j = 6'h02;
	localparam opcode_t op_beq = 6'h04;
	localparam opcode_t op_bne = 6'h05;
	localparam opcode_t op_addi = 6'h08;
	localparam opcode_t op_slti = 6'h0a;
	localparam opcode_t op_lw = 6'h23;
	localparam opcode_t op_sw = 6'h2b;

	localparam funct_t fn_add = 6'h20;
	localparam funct_t fn_sub = 6'h22;
	localparam funct_t fn_and = 6'h24;
	localparam funct_t fn_slt = 6'h2a;
	localparam funct_t fn_mult = 6'h18;
	localparam funct_t fn_mfhi = 6'h10;
	localparam funct_t fn_mflo = 6'h12;

endpackage

// File: logic/mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic               clock,
	input  logic               reset,
	input  logic               ack,
	input  isa_pkg::word_t     rdata,
	output logic               req,
	output ctrl_pkg::mem_req_t mem_req
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	ctrl_t ctrl;
	instr_t ir;
	word_t pc;
	word_t a_q;
	word_t b_q;
	word_t alu_out;
	word_t mdr;
	word_t rs_data;
	word_t rt_data;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t imm_ext;
	word_t jump_target;
	word_t pc_next;
	word_t wb_data;
	word_t hi;
	word_t lo;
	reg_addr_t dst_addr;
	logic zero;
	logic mult_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pc_write) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clock) begin
		if (ctrl.ir_write) begin
			ir <= rdata;
		end
		if (ctrl.mdr_write) begin
			mdr <= rdata;
		end
		if (ctrl.ab_write) begin
			a_q <= rs_data;
			b_q <= rt_data;
		end
		if (ctrl.alu_out_write) begin
			alu_out <= alu_result;
		end
	end

	assign imm_ext = {{(word_w - imm_w){ir.i.imm[imm_w-1]}}, ir.i.imm};
	assign jump_target = {pc[word_w-1 -: (word_w - target_w - 2)], ir.j.target, 2'b00};

	always_comb begin
		case (ctrl.alu_a_sel)
			a_pc: alu_a = pc;
			default: alu_a = a_q;
		endcase
		case (ctrl.alu_b_sel)
			b_reg: alu_b = b_q;
			b_four: alu_b = word_t'(4);
			b_imm: alu_b = imm_ext;
			default: alu_b = imm_ext << 2; // branch offset in words
		endcase
		case (ctrl.wb_sel)
			wb_alu: wb_data = alu_out;
			wb_mdr: wb_data = mdr;
			wb_hi: wb_data = hi;
			default: wb_data = lo;
		endcase
		case (ctrl.pc_sel)
			pc_alu: pc_next = alu_result;
			pc_alu_out: pc_next = alu_out;
			default: pc_next = jump_target;
		endcase
	end

	assign dst_addr = (ctrl.dst_sel == dst_rd) ? ir.r.rd : ir.i.rt;

	assign req = ctrl.mem_req;
	assign mem_req = '{
		addr: (ctrl.addr_from_alu ? alu_out : pc),
		wdata: b_q,
		we: ctrl.mem_we
	};

	control_fsm u_fsm (
		.clock(clock),
		.reset(reset),
		.opcode(ir.r.opcode),
		.funct(ir.r.funct),
		.zero(zero),
		.ack(ack),
		.mult_done(mult_done),
		.ctrl(ctrl)
	);

	step_counter u_steps (
		.clock(clock),
		.reset(reset),
		.start(ctrl.mult_start),
		.step(ctrl.mult_step),
		.done(mult_done)
	);

	register_file u_regs (
		.clock(clock),
		.reset(reset),
		.write_en(ctrl.reg_write),
		.rs_addr(ir.r.rs),
		.rt_addr(ir.r.rt),
		.rd_addr(dst_addr),
		.write_data(wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	alu u_alu (
		.op(ctrl.alu_op),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result),
		.zero(zero)
	);

	mult_unit u_mult (
		.clock(clock),
		.reset(reset),
		.start(ctrl.mult_start),
		.step(ctrl.mult_step),
		.multiplicand(a_q),
		.multiplier(b_q),
		.hi(hi),
		.lo(lo)
	);

endmodule

// File: logic/mult_unit.sv
`timescale 1ns/1ps

module mult_unit (
	input  logic           clock,
	input  logic           reset,
	input  logic           start,
	input  logic           step,
	input  isa_pkg::word_t multiplicand,
	input  isa_pkg::word_t multiplier,
	output isa_pkg::word_t hi,
	output isa_pkg::word_t lo
);
	import isa_pkg::*;

	word_t mcand;
	logic [word_w:0] sum; // carry out in the top bit

	// add multiplicand when the current multiplier bit is set
	assign sum = {1'b0, hi} + (lo[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (start) begin
			hi <= '0;
			lo <= multiplier; // shifted out as product bits come in
		end else if (step) begin
			hi <= sum[word_w:1];
			lo <= {sum[0], lo[word_w-1:1]};
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			mcand <= multiplicand;
		end
	end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic               clock,
	input  logic               reset,
	input  logic               write_en,
	input  isa_pkg::reg_addr_t rs_addr,
	input  isa_pkg::reg_addr_t rt_addr,
	input  isa_pkg::reg_addr_t rd_addr,
	input  isa_pkg::word_t     write_data,
	output isa_pkg::word_t     rs_data,
	output isa_pkg::word_t     rt_data
);
	import isa_pkg::*;

	word_t regs [num_regs];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && (rd_addr != '0)) begin
			regs[rd_addr] <= write_data; // r0 stays zero
		end
	end

	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: logic/step_counter.sv
`timescale 1ns/1ps

module step_counter (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic step,
	output logic done
);
	import isa_pkg::*;

	logic [mult_cnt_w-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (start) begin
			count <= '0;
		end else if (step) begin
			count <= count + 1'b1;
		end
	end

	// high during the step that completes the last count
	assign done = step && (count == mult_cnt_w'(mult_steps - 1));

endmodule

// File: src.f
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/step_counter.sv
logic/mult_unit.sv
logic/control_fsm.sv
logic/mips_core.sv
test/mem_model.sv
test/tb_mips_core.sv

// File: test/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
	parameter int unsigned seed = 1
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               req,
	input  ctrl_pkg::mem_req_t mem_req,
	output logic               ack,
	output isa_pkg::word_t     rdata,
	output logic               store_valid, // one cycle per completed write
	output isa_pkg::word_t     store_addr,
	output isa_pkg::word_t     store_data
);
	import isa_pkg::*;

	localparam int mem_words = 256;
	localparam int idx_w = $clog2(mem_words);
	localparam int max_delay = 5;

	word_t mem [mem_words];

	function automatic word_t r_instr(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, funct_t fn);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_instr(opcode_t op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_instr(logic [25:0] target);
		return {op_j, target};
	endfunction

	task automatic load_program();
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = 32'h5a5a_0000 ^ word_t'(i << 2);
		end
		mem[0] = i_instr(op_addi, 5'd0, 5'd1, 16'h0200); // r1 = store base
		mem[1] = i_instr(op_addi, 5'd0, 5'd2, 16'h1234);
		mem[2] = i_instr(op_addi, 5'd0, 5'd3, 16'hfffb); // -5
		mem[3] = r_instr(5'd2, 5'd3, 5'd4, fn_add);
		mem[4] = i_instr(op_sw, 5'd1, 5'd4, 16'h0000);
		mem[5] = r_instr(5'd3, 5'd2, 5'd5, fn_sub);
		mem[6] = i_instr(op_sw, 5'd1, 5'd5, 16'h0004);
		mem[7] = r_instr(5'd2, 5'd3, 5'd6, fn_and);
		mem[8] = i_instr(op_sw, 5'd1, 5'd6, 16'h0008);
		mem[9] = i_instr(op_addi, 5'd2, 5'd7, 16'hed00); // -0x1300
		mem[10] = i_instr(op_sw, 5'd1, 5'd7, 16'h000c);
		mem[11] = r_instr(5'd3, 5'd2, 5'd8, fn_slt);
		mem[12] = i_instr(op_sw, 5'd1, 5'd8, 16'h0010);
		mem[13] = r_instr(5'd2, 5'd3, 5'd9, fn_slt);
		mem[14] = i_instr(op_sw, 5'd1, 5'd9, 16'h0014);
		mem[15] = i_instr(op_slti, 5'd3, 5'd10, 16'hfffc); // -4
		mem[16] = i_instr(op_sw, 5'd1, 5'd10, 16'h0018);
		mem[17] = i_instr(op_slti, 5'd2, 5'd11, 16'hfffc);
		mem[18] = i_instr(op_sw, 5'd1, 5'd11, 16'h001c);
		mem[19] = i_instr(op_lw, 5'd1, 5'd12, 16'h0100); // from 0x300
		mem[20] = i_instr(op_sw, 5'd1, 5'd12, 16'h0020);
		mem[21] = i_instr(op_beq, 5'd2, 5'd2, 16'h0001); // taken
		mem[22] = i_instr(op_sw, 5'd1, 5'd2, 16'h0024);
		mem[23] = i_instr(op_bne, 5'd2, 5'd3, 16'h0001); // taken
		mem[24] = i_instr(op_sw, 5'd1, 5'd3, 16'h0024);
		mem[25] = i_instr(op_beq, 5'd2, 5'd3, 16'h0001); // not taken
		mem[26] = i_instr(op_sw, 5'd1, 5'd3, 16'h0024);
		mem[27] = i_instr(op_bne, 5'd2, 5'd2, 16'h0001); // not taken
		mem[28] = i_instr(op_sw, 5'd1, 5'd2, 16'h0028);
		mem[29] = j_instr(26'd31);
		mem[30] = i_instr(op_sw, 5'd1, 5'd0, 16'h002c); // jumped over
		mem[31] = r_instr(5'd2, 5'd3, 5'd0, fn_mult);
		mem[32] = r_instr(5'd0, 5'd0, 5'd13, fn_mfhi);
		mem[33] = r_instr(5'd0, 5'd0, 5'd14, fn_mflo);
		mem[34] = i_instr(op_sw, 5'd1, 5'd13, 16'h002c);
		mem[35] = i_instr(op_sw, 5'd1, 5'd14, 16'h0030);
		mem[36] = j_instr(26'd36); // spin here
		mem[192] = 32'hdeadbeef;
	endtask

	initial begin
		int remaining;
		int idx;
		remaining = -1;
		ack = 1'b0;
		rdata = '0;
		store_valid = 1'b0;
		store_addr = '0;
		store_data = '0;
		void'($urandom(seed));
		load_program();
		forever begin
			@(negedge clock);
			store_valid <= 1'b0;
			if (reset) begin
				ack <= 1'b0;
				remaining = -1;
			end else if (ack) begin
				if (!req) begin
					ack <= 1'b0; // release phase
					remaining = -1;
				end
			end else if (req) begin
				if (remaining < 0) begin
					remaining = $urandom_range(max_delay, 0);
				end
				if (remaining == 0) begin
					idx = int'(mem_req.addr[idx_w+1:2]);
					if (mem_req.we) begin
						mem[idx] = mem_req.wdata;
						store_valid <= 1'b1;
						store_addr <= mem_req.addr;
						store_data <= mem_req.wdata;
					end else begin
						rdata <= mem[idx];
					end
					ack <= 1'b1;
				end else begin
					remaining--;
				end
			end
		end
	end

endmodule

// File: test/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
	import isa_pkg::*;
	import ctrl_pkg::*;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	localparam int num_stores = 13;
	localparam int timeout_cycles = num_stores * 60;
	localparam int drain_cycles = 100; // watch for stray stores

	logic clock;
	logic reset;
	logic req;
	logic ack;
	word_t rdata;
	mem_req_t mem_req;
	logic store_valid;
	word_t store_addr;
	word_t store_data;

	store_t expected [num_stores];
	int cycle_count;
	int mismatches;
	int protocol_errors;
	int other_errors;
	logic prev_req;

	mips_core uut (
		.clock(clock),
		.reset(reset),
		.ack(ack),
		.rdata(rdata),
		.req(req),
		.mem_req(mem_req)
	);

	mem_model #(.seed(49183)) u_mem (
		.clock(clock),
		.reset(reset),
		.req(req),
		.mem_req(mem_req),
		.ack(ack),
		.rdata(rdata),
		.store_valid(store_valid),
		.store_addr(store_addr),
		.store_data(store_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		if (reset) begin
			cycle_count <= 0;
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	// four-phase rule, sampled where req and ack are both settled
	always @(negedge clock) begin
		if (reset) begin
			prev_req <= 1'b0;
		end else begin
			if (prev_req && !req && !ack) begin
				protocol_errors++;
				$display("at %0t: req dropped before ack arrived", $time);
			end
			if (!prev_req && req && ack) begin
				protocol_errors++;
				$display("at %0t: req raised while ack was still high", $time);
			end
			prev_req <= req;
		end
	end

	task automatic fill_expected();
		logic [63:0] product;
		product = 64'(32'h0000_1234) * 64'(32'hffff_fffb); // unsigned
		expected[0] = '{addr: 32'h200, data: 32'h0000_122f}; // 0x1234 + -5
		expected[1] = '{addr: 32'h204, data: 32'hffff_edc7}; // -5 - 0x1234
		expected[2] = '{addr: 32'h208, data: 32'h0000_1230};
		expected[3] = '{addr: 32'h20c, data: 32'hffff_ff34}; // 0x1234 - 0x1300
		expected[4] = '{addr: 32'h210, data: 32'd1};
		expected[5] = '{addr: 32'h214, data: 32'd0};
		expected[6] = '{addr: 32'h218, data: 32'd1}; // -5 < -4
		expected[7] = '{addr: 32'h21c, data: 32'd0};
		expected[8] = '{addr: 32'h220, data: 32'hdead_beef};
		expected[9] = '{addr: 32'h224, data: 32'hffff_fffb}; // only the fall-through store
		expected[10] = '{addr: 32'h228, data: 32'h0000_1234};
		expected[11] = '{addr: 32'h22c, data: product[63:32]};
		expected[12] = '{addr: 32'h230, data: product[31:0]};
	endtask

	task automatic next_store(output logic got, output store_t seen);
		got = 1'b0;
		seen = '0;
		while (!got && cycle_count < timeout_cycles) begin
			@(posedge clock);
			if (store_valid) begin
				got = 1'b1;
				seen = '{addr: store_addr, data: store_data};
			end
		end
	endtask

	initial begin
		store_t seen;
		logic got;
		int checked;
		int extra;
		reset = 1'b1;
		mismatches = 0;
		protocol_errors = 0;
		other_errors = 0;
		checked = 0;
		extra = 0;
		fill_expected();
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		if (req !== 1'b0) begin
			other_errors++;
			$display("at %0t: req is not low right after reset", $time);
		end
		for (int i = 0; i < num_stores; i++) begin
			next_store(got, seen);
			if (!got) begin
				other_errors++;
				$display("timeout after %0d cycles: only %0d of %0d stores seen",
					cycle_count, i, num_stores);
				break;
			end
			if (seen.addr !== expected[i].addr) begin
				mismatches++;
				$display("Mismatch at %0t: store_addr expected %h got %h",
					$time, expected[i].addr, seen.addr);
			end
			if (seen.data !== expected[i].data) begin
				mismatches++;
				$display("Mismatch at %0t: store_data expected %h got %h",
					$time, expected[i].data, seen.data);
			end
			checked++;
		end
		if (checked == num_stores) begin
			repeat (drain_cycles) begin
				@(posedge clock);
				if (store_valid) begin
					extra++;
				end
			end
			if (extra != 0) begin
				other_errors++;
				$display("%0d extra stores after the last expected one", extra);
			end
		end
		$display("checked %0d stores: %0d mismatches, %0d protocol errors, %0d other errors",
			checked, mismatches, protocol_errors, other_errors);
		if (mismatches == 0 && protocol_errors == 0 && other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
